// File: dv/bitcnt_unit_tb.sv
/* Bit-count unit testbench */

`timescale 1ns/1ps

module bitcnt_unit_tb
    import bitcnt_pkg::*;
();

    localparam int XLEN       = 64;
    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 8;
    localparam int N_OPS1     = 1500;
    localparam int N_OPS2     = 1000;
    localparam int DRAIN      = 6;
    // Random phases, in-flight reset sequence (3 issues, 1 assert, 3 hold) and drain
    localparam int STIM_CYCLES = N_OPS1 + N_OPS2 + 7 + DRAIN + 1;
    localparam int TIMEOUT     = (STIM_CYCLES + RST_CYCLES + 20) * CLK_PERIOD;

    // One expected result, with the cycle at which the checker must see it
    typedef struct packed {
        logic [31:0]      due;
        logic [TAG_W-1:0] tag;
        logic [63:0]      result;
    } exp_t;

    // Clock starts low before any process runs, so time zero has no falling edge
    logic             clk = 1'b0;
    logic             rst_n;
    logic             in_valid;
    bitcnt_ctrl_t     in_ctrl;
    logic [XLEN-1:0]  in_operand;
    logic             out_valid;
    logic [TAG_W-1:0] out_tag;
    logic [XLEN-1:0]  out_result;

    logic [31:0] lfsr;
    logic [31:0] cyc;
    logic        rst_q;
    exp_t        exp_q[$];

    bitcnt_unit #(
        .XLEN (XLEN)
    ) bitcnt_unit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ctrl    (in_ctrl),
        .in_operand (in_operand),
        .out_valid  (out_valid),
        .out_tag    (out_tag),
        .out_result (out_result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Cycle count and the reset level as the DUT samples it on each edge
    always @(posedge clk) begin
        cyc   <= cyc + 1;
        rst_q <= rst_n;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    // Galois LFSR, x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    function automatic bitcnt_op_e op_from_index(input logic [2:0] idx);
        case (idx)
            3'd0, 3'd6: return CPOP;
            3'd1, 3'd7: return CLZ;
            3'd2: return CTZ;
            3'd3: return CPOPW;
            3'd4: return CLZW;
            default: return CTZW;
        endcase
    endfunction

    // Reference model, counts bit by bit over the active width
    function automatic logic [63:0] expected_result(input bitcnt_op_e op,
                                                    input logic [63:0] opnd);
        int   width;
        int   cnt;
        logic found;
        width = (op == CPOPW || op == CLZW || op == CTZW) ? 32 : XLEN;
        cnt   = 0;
        found = 1'b0;
        case (op)
            CPOP, CPOPW: begin
                for (int i = 0; i < width; i++) begin
                    if (opnd[i]) cnt++;
                end
            end
            CTZ, CTZW: begin
                for (int i = 0; i < width; i++) begin
                    if (opnd[i]) found = 1'b1;
                    else if (!found) cnt++;
                end
            end
            default: begin
                for (int i = width - 1; i >= 0; i--) begin
                    if (opnd[i]) found = 1'b1;
                    else if (!found) cnt++;
                end
            end
        endcase
        return 64'(cnt);
    endfunction

    // Drives one cycle of stimulus and records what should come out
    task automatic drive_random(input logic force_valid);
        logic [63:0]  r;
        logic [63:0]  opnd;
        logic         v;
        bitcnt_op_e   op;
        bitcnt_ctrl_t ctrl;
        exp_t         e;
        take_bits(2, r);
        v = force_valid || (r[1:0] != 2'b00);
        take_bits(3, r);
        op = op_from_index(r[2:0]);
        take_bits(TAG_W, r);
        ctrl.op  = op;
        ctrl.tag = r[TAG_W-1:0];
        take_bits(64, opnd);
        take_bits(3, r);
        case (r[2:0])
            3'd0: opnd = '0;
            3'd1: opnd = '1;
            3'd2: begin
                take_bits(6, r);
                opnd = 64'd1 << r[5:0];
            end
            3'd3: opnd[31:0] = '0;
            3'd4: opnd[63:32] = '0;
            default: ;
        endcase
        // Word forms get garbage above bit 31
        if (op == CPOPW || op == CLZW || op == CTZW) begin
            take_bits(32, r);
            opnd[63:32] = r[31:0];
        end
        in_valid   <= v;
        in_ctrl    <= ctrl;
        in_operand <= opnd;
        if (v) begin
            e.due    = cyc + 3;
            e.tag    = ctrl.tag;
            e.result = expected_result(op, opnd);
            exp_q.push_back(e);
        end
    endtask

    // Issues a burst, then resets while the last of it is still in the pipeline
    task automatic reset_in_flight();
        repeat (3) begin
            @(posedge clk);
            drive_random(1'b1);
        end
        @(posedge clk);
        rst_n    <= 1'b0;
        in_valid <= 1'b0;
        while (exp_q.size() != 0 && exp_q[$].due > cyc + 1) begin
            void'(exp_q.pop_back());
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // Scoreboard, sampled away from the rising edge
    always @(negedge clk) begin
        exp_t head;
        if (!rst_q) begin
            assert (out_valid == 1'b0)
                else report_fail($sformatf("error out_valid got %h expected 0", out_valid));
        end else if (out_valid) begin
            assert (exp_q.size() != 0)
                else report_fail("A result came out with no matching operation");
            head = exp_q.pop_front();
            assert (head.due == cyc)
                else report_fail($sformatf("Result for tag %h came out at cycle %0d not %0d",
                                           head.tag, cyc, head.due));
            assert (out_tag == head.tag)
                else report_fail($sformatf("error out_tag got %h expected %h",
                                           out_tag, head.tag));
            assert (out_result == head.result)
                else report_fail($sformatf("error out_result got %h expected %h",
                                           out_result, head.result));
        end else if (exp_q.size() != 0) begin
            assert (exp_q[0].due != cyc)
                else report_fail("An issued operation produced no result when it was due");
        end
    end

    initial begin
        #(TIMEOUT);
        report_fail("Watchdog timeout, the test did not finish in time");
    end

    initial begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_ctrl    = '0;
        in_operand = '0;
        lfsr       = 32'd84711;
        cyc        = '0;
        rst_q      = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (N_OPS1) begin
            @(posedge clk);
            drive_random(1'b0);
        end
        reset_in_flight();
        repeat (N_OPS2) begin
            @(posedge clk);
            drive_random(1'b0);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        repeat (DRAIN) @(posedge clk);
        if (exp_q.size() != 0) begin
            report_fail($sformatf("%0d issued operations never produced a result",
                                  exp_q.size()));
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// File: list.f
rtl/bitcnt_pkg.sv
rtl/bitcnt_plc8.sv
rtl/bitcnt_operand_prep.sv
rtl/bitcnt_pop_tree.sv
rtl/bitcnt_unit.sv
dv/bitcnt_unit_tb.sv

// File: rtl/bitcnt_operand_prep.sv
/* Operand preparation stage */

`timescale 1ns/1ps

module bitcnt_operand_prep
    import bitcnt_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  bitcnt_ctrl_t     in_ctrl,
    input  logic [XLEN-1:0]  in_operand,
    output logic             prep_valid,
    output logic [TAG_W-1:0] prep_tag,
    output logic [XLEN-1:0]  prep_vec
);

    logic            word_op;
    logic            clz_op;
    logic            zero_op;
    logic [XLEN-1:0] win_mask;
    logic [XLEN-1:0] windowed;
    logic [XLEN-1:0] rev_full;
    logic [XLEN-1:0] rev_word;
    logic [XLEN-1:0] cnt_src;
    logic [XLEN-1:0] zero_mask;
    logic [XLEN-1:0] vec_next;

    // Decode the opcode into the three choices the datapath needs
    assign word_op = is_word_op(in_ctrl.op);
    assign clz_op  = (in_ctrl.op == CLZ) || (in_ctrl.op == CLZW);
    assign zero_op = !((in_ctrl.op == CPOP) || (in_ctrl.op == CPOPW));

    // Active window is the low word for W forms, the full register otherwise.
    // With XLEN of 32 both windows are the same
    assign win_mask = word_op ? XLEN'(32'hFFFF_FFFF) : '1;
    assign windowed = in_operand & win_mask;

    // Leading zeros become trailing zeros once the window is mirrored
    always_comb begin
        rev_full = '0;
        rev_word = '0;
        for (int i = 0; i < XLEN; i++) begin
            rev_full[i] = windowed[XLEN-1-i];
        end
        for (int i = 0; i < 32; i++) begin
            rev_word[i] = windowed[31-i];
        end
    end

    assign cnt_src = clz_op ? (word_op ? rev_word : rev_full) : windowed;

    // Ones only where cnt_src has zeros below its lowest set bit.
    // A zero source gives all ones, trimmed back to the active window
    assign zero_mask = ~cnt_src & (cnt_src - 1'b1) & win_mask;

    assign vec_next = zero_op ? zero_mask : windowed;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prep_valid <= 1'b0;
        end else begin
            prep_valid <= in_valid;
        end
    end

    // Payload only moves when there is something to carry
    always_ff @(posedge clk) begin
        if (in_valid) begin
            prep_tag <= in_ctrl.tag;
            prep_vec <= vec_next;
        end
    end

endmodule

// File: rtl/bitcnt_pkg.sv
/* Bit-count unit shared types */

package bitcnt_pkg;

    // Width of the tag, one value per reorder slot of the enclosing core
    localparam int TAG_W = 5;

    // Zbb counting operations
    // Bit 2 marks the 32-bit word forms
    typedef enum logic [2:0] {
        CPOP  = 3'b000,
        CLZ   = 3'b001,
        CTZ   = 3'b010,
        CPOPW = 3'b100,
        CLZW  = 3'b101,
        CTZW  = 3'b110
    } bitcnt_op_e;

    // Control that travels alongside the data through both stages
    typedef struct packed {
        bitcnt_op_e       op;
        logic [TAG_W-1:0] tag;
    } bitcnt_ctrl_t;

    // True for the forms that only look at bits 31 to 0
    function automatic logic is_word_op(input bitcnt_op_e op);
        logic w;
        case (op)
            CPOPW, CLZW, CTZW: w = 1'b1;
            default: w = 1'b0;
        endcase
        return w;
    endfunction

    // Bits needed to hold a count from 0 up to xlen inclusive
    function automatic int cnt_w(input int xlen);
        int w;
        w = $clog2(xlen) + 1;
        return w;
    endfunction

endpackage

// File: rtl/bitcnt_plc8.sv
/* Byte population count */

`timescale 1ns/1ps

module bitcnt_plc8 (
    input  wire logic [7:0] a,
    output logic      [3:0] b
);

    // Builds all 256 byte counts, 4 bits per entry, entry i at bits 4*i+3 to 4*i
    function automatic logic [1023:0] build_lut();
        logic [1023:0] t;
        logic [3:0]    c;
        logic [7:0]    v;
        t = '0;
        for (int i = 0; i < 256; i++) begin
            v = 8'(i);
            c = '0;
            for (int k = 0; k < 8; k++) begin
                c = c + {3'b000, v[k]};
            end
            t[i*4 +: 4] = c;
        end
        return t;
    endfunction

    // Table is a constant, so it folds into plain logic in synthesis
    localparam logic [1023:0] CPOP_LUT = build_lut();

    assign b = CPOP_LUT[{a, 2'b00} +: 4];

endmodule

// File: rtl/bitcnt_pop_tree.sv
/* Population count adder tree stage */

`timescale 1ns/1ps

module bitcnt_pop_tree
    import bitcnt_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             prep_valid,
    input  logic [TAG_W-1:0] prep_tag,
    input  logic [XLEN-1:0]  prep_vec,
    output logic             out_valid,
    output logic [TAG_W-1:0] out_tag,
    output logic [XLEN-1:0]  out_result
);

    localparam int NB    = XLEN / 8;
    localparam int LVLS  = $clog2(NB);
    localparam int CNT_W = cnt_w(XLEN);

    logic [CNT_W-1:0] total;

    // Level l holds NB >> l partial sums, each 4 + l bits wide.
    // Level 0 is the per-byte lookup, the last level is a single sum
    for (genvar l = 0; l <= LVLS; l++) begin : lvl
        logic [4+l-1:0] sum [NB >> l];

        if (l == 0) begin : leaf
            for (genvar j = 0; j < NB; j++) begin : byte_cnt
                bitcnt_plc8 plc8_inst (
                    .a (prep_vec[j*8 +: 8]),
                    .b (sum[j])
                );
            end
        end else begin : node
            for (genvar j = 0; j < (NB >> l); j++) begin : add
                // Result is one bit wider than the operands, so the carry is kept
                assign sum[j] = lvl[l-1].sum[2*j] + lvl[l-1].sum[2*j+1];
            end
        end
    end

    // Root width is 4 + log2(NB), which equals CNT_W for XLEN of 32 or 64
    assign total = lvl[LVLS].sum[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= prep_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (prep_valid) begin
            out_tag    <= prep_tag;
            out_result <= XLEN'(total);
        end
    end

endmodule

// File: rtl/bitcnt_unit.sv
/* Zbb bit-count execution unit */

`timescale 1ns/1ps

module bitcnt_unit
    import bitcnt_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  bitcnt_ctrl_t     in_ctrl,
    input  logic [XLEN-1:0]  in_operand,
    output logic             out_valid,
    output logic [TAG_W-1:0] out_tag,
    output logic [XLEN-1:0]  out_result
);

    // Stage boundary between operand preparation and counting
    logic             prep_valid;
    logic [TAG_W-1:0] prep_tag;
    logic [XLEN-1:0]  prep_vec;

    // First cycle reduces every operation to a population count
    bitcnt_operand_prep #(
        .XLEN (XLEN)
    ) bitcnt_operand_prep_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ctrl    (in_ctrl),
        .in_operand (in_operand),
        .prep_valid (prep_valid),
        .prep_tag   (prep_tag),
        .prep_vec   (prep_vec)
    );

    // Second cycle counts the prepared vector
    bitcnt_pop_tree #(
        .XLEN (XLEN)
    ) bitcnt_pop_tree_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .prep_valid (prep_valid),
        .prep_tag   (prep_tag),
        .prep_vec   (prep_vec),
        .out_valid  (out_valid),
        .out_tag    (out_tag),
        .out_result (out_result)
    );

endmodule
